/* include/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// sizing of the memory side

// extra cycles the block memory stalls before it answers
// the answer lands WAIT_CYCLES+1 edges after the request is taken
`define WAIT_CYCLES 2

// words moved per block transfer
// also the number of words held by one cache line
`define BLOCK_WORDS 4

// words in the memory window, 16 KB
// higher address bits alias into this window
`define MEM_WORDS 4096

// lines in the direct-mapped cache
// must stay a power of two, index is taken straight from the address
`define CACHE_LINES 16

// field split of a byte address follows from the values above
// offset at bits 3..2, index at 7..4, tag at 13..8

`endif

/* hw/memTypesPkg.sv */
`default_nettype none

`include "mem_consts.svh"

package memTypesPkg;

  // one data word and a byte address
  typedef logic [31:0] wordT;
  typedef logic [31:0] addrT;

  // whole block, word 0 in the low bits
  typedef wordT [`BLOCK_WORDS-1:0] blockT;

  // memory model sequencing
  typedef enum logic [1:0] {memIdle, memWait, memDone} memStateT;

  // preload value for a word address
  function automatic wordT initWord(input logic [31:0] wordAddr);
    return (wordAddr * 32'h01010101) ^ 32'hA5A50000;
  endfunction

endpackage

`default_nettype wire

/* hw/cacheTypesPkg.sv */
`default_nettype none

`include "mem_consts.svh"

package cacheTypesPkg;

  // controller FSM states
  typedef enum logic [1:0] {cIdle, cCompare, cWriteBack, cRefill} cacheStateT;

  // processor opcodes
  typedef enum logic {opLoad, opStore} cpuOpT;

  // word within a block
  typedef logic [$clog2(`BLOCK_WORDS)-1:0] offsetT;

  // line select
  typedef logic [$clog2(`CACHE_LINES)-1:0] indexT;

  // what is left of the word address inside the window
  typedef logic [$clog2(`MEM_WORDS)-$clog2(`BLOCK_WORDS)-$clog2(`CACHE_LINES)-1:0] tagT;

endpackage

`default_nettype wire

/* hw/memBusIf.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_consts.svh"

// block transfer bus between cache and block memory
interface memBusIf import memTypesPkg::*; ();

  // request side, driven by the cache
  logic  re;
  logic  we;
  addrT  addr;
  blockT wd;

  // answer side, driven by the memory
  blockT rd;
  logic  valid;

  // cache end
  modport master (output re, we, addr, wd, input rd, valid);

  // memory end
  modport slave (input re, we, addr, wd, output rd, valid);

endinterface

`default_nettype wire

/* hw/blockMemory.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_consts.svh"

module blockMemory import memTypesPkg::*; (
  input logic     clk,
  input logic     rstN,
  memBusIf.slave  bus
);

  // counter wide enough for WAIT_CYCLES, at least one bit
  localparam int CountW = $clog2(`WAIT_CYCLES + 2);
  // byte offset bits below the block number
  localparam int BlkLsb = $clog2(`BLOCK_WORDS) + 2;
  // block number bits inside the window
  localparam int BlkW = $clog2(`MEM_WORDS / `BLOCK_WORDS);

  memStateT           state;
  logic [CountW-1:0]  count;
  logic [BlkW-1:0]    blkSel;
  logic               lastWait;

  wordT mem [`MEM_WORDS];

  // fixed pattern instead of a data file
  initial
  begin
    for (int i = 0; i < `MEM_WORDS; i++)
      mem[i] = initWord(i);
  end

  // upper address bits alias into the window
  assign blkSel = bus.addr[BlkLsb +: BlkW];
  // last stall cycle, the answer is taken at the next edge
  assign lastWait = (state == memWait) && (count == CountW'(`WAIT_CYCLES));
  assign bus.valid = (state == memDone);

  // wait-state sequencer
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= memIdle;
      count <= '0;
    end
    else
    begin
      case (state)
        memIdle:
        begin
          if (bus.re || bus.we)
          begin
            state <= memWait;
            count <= '0;
          end
        end
        memWait:
        begin
          if (lastWait)
            state <= memDone;
          else
            count <= count + 1'b1;
        end
        // one cycle of valid, then ready again
        memDone:
          state <= memIdle;
        default:
          state <= memIdle;
      endcase
    end
  end

  // array access at the edge that raises valid
  always_ff @(posedge clk)
  begin
    if (lastWait)
    begin
      for (int w = 0; w < `BLOCK_WORDS; w++)
      begin
        bus.rd[w] <= mem[int'(blkSel) * `BLOCK_WORDS + w];
        if (bus.we)
          mem[int'(blkSel) * `BLOCK_WORDS + w] <= bus.wd[w];
      end
    end
  end

  // only one kind of request at a time
  assert property (@(posedge clk) disable iff (!rstN) !(bus.re && bus.we))
    else $error("blockMemory: re and we high together");

  // answer is a single-cycle pulse
  assert property (@(posedge clk) disable iff (!rstN) bus.valid |=> !bus.valid)
    else $error("blockMemory: valid held longer than one cycle");

  // master must not move the request while we stall
  assert property (@(posedge clk) disable iff (!rstN)
    (state == memWait) |-> $stable({bus.re, bus.we, bus.addr, bus.wd}))
    else $error("blockMemory: request changed during wait");

endmodule

`default_nettype wire

/* hw/cacheController.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_consts.svh"

module cacheController import memTypesPkg::*, cacheTypesPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    cpuReq,
  input  cpuOpT   cpuOp,
  input  addrT    cpuAddr,
  input  wordT    cpuWdata,
  output wordT    cpuRdata,
  output logic    cpuReady,
  memBusIf.master bus
);

  // field positions in the byte address
  localparam int OffLsb = 2;
  localparam int IdxLsb = OffLsb + $bits(offsetT);
  localparam int TagLsb = IdxLsb + $bits(indexT);

  cacheStateT state;

  // latched processor request
  cpuOpT  reqOp;
  addrT   reqAddr;
  wordT   reqWdata;
  offsetT reqOff;
  indexT  reqIdx;
  tagT    reqTag;

  // per-line state
  logic [`CACHE_LINES-1:0] validBits;
  logic [`CACHE_LINES-1:0] dirtyBits;
  tagT   tagArr  [`CACHE_LINES];
  blockT dataArr [`CACHE_LINES];

  // registered memory request
  logic  memRe;
  logic  memWe;
  addrT  memAddr;
  blockT memWd;

  logic hit;
  logic needWb;
  addrT victimAddr;
  addrT refillAddr;

  assign reqOff = reqAddr[OffLsb +: $bits(offsetT)];
  assign reqIdx = reqAddr[IdxLsb +: $bits(indexT)];
  assign reqTag = reqAddr[TagLsb +: $bits(tagT)];

  assign hit    = validBits[reqIdx] && (tagArr[reqIdx] == reqTag);
  assign needWb = validBits[reqIdx] && dirtyBits[reqIdx];

  // block addresses, bits above the window stay zero
  assign victimAddr = addrT'({tagArr[reqIdx], reqIdx, {IdxLsb{1'b0}}});
  assign refillAddr = addrT'({reqTag, reqIdx, {IdxLsb{1'b0}}});

  // hit answers straight from the compare cycle
  assign cpuReady = (state == cCompare) && hit;
  assign cpuRdata = dataArr[reqIdx][reqOff];

  assign bus.re   = memRe;
  assign bus.we   = memWe;
  assign bus.addr = memAddr;
  assign bus.wd   = memWd;

  // FSM and line flags
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state     <= cIdle;
      memRe     <= 1'b0;
      memWe     <= 1'b0;
      validBits <= '0;
      dirtyBits <= '0;
    end
    else
    begin
      case (state)
        // strobes outside idle are dropped
        cIdle:
        begin
          if (cpuReq)
            state <= cCompare;
        end
        cCompare:
        begin
          if (hit)
          begin
            if (reqOp == opStore)
              dirtyBits[reqIdx] <= 1'b1;
            state <= cIdle;
          end
          else if (needWb)
          begin
            memWe <= 1'b1;
            state <= cWriteBack;
          end
          else
          begin
            memRe <= 1'b1;
            state <= cRefill;
          end
        end
        // victim out, then straight into the refill read
        cWriteBack:
        begin
          if (bus.valid)
          begin
            memWe <= 1'b0;
            memRe <= 1'b1;
            state <= cRefill;
          end
        end
        // line comes back clean, compare again to answer
        cRefill:
        begin
          if (bus.valid)
          begin
            memRe             <= 1'b0;
            validBits[reqIdx] <= 1'b1;
            dirtyBits[reqIdx] <= 1'b0;
            state             <= cCompare;
          end
        end
        default:
          state <= cIdle;
      endcase
    end
  end

  // request latch, arrays and bus payload
  always_ff @(posedge clk)
  begin
    if ((state == cIdle) && cpuReq)
    begin
      reqOp    <= cpuOp;
      reqAddr  <= cpuAddr;
      reqWdata <= cpuWdata;
    end
    // store hit merges one word
    if ((state == cCompare) && hit && (reqOp == opStore))
      dataArr[reqIdx][reqOff] <= reqWdata;
    if ((state == cCompare) && !hit)
    begin
      memAddr <= needWb ? victimAddr : refillAddr;
      memWd   <= dataArr[reqIdx];
    end
    if ((state == cWriteBack) && bus.valid)
      memAddr <= refillAddr;
    if ((state == cRefill) && bus.valid)
    begin
      dataArr[reqIdx] <= bus.rd;
      tagArr[reqIdx]  <= reqTag;
    end
  end

  // ready is a pulse, the FSM leaves compare on a hit
  assert property (@(posedge clk) disable iff (!rstN) cpuReady |=> !cpuReady)
    else $error("cacheController: cpuReady held longer than one cycle");

  // memory only sees traffic while a miss is being served
  assert property (@(posedge clk) disable iff (!rstN)
    (bus.re || bus.we) |-> (state inside {cWriteBack, cRefill}))
    else $error("cacheController: memory request outside miss handling");

endmodule

`default_nettype wire

/* hw/memSubsystem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_consts.svh"

module memSubsystem import memTypesPkg::*, cacheTypesPkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  logic  cpuReq,
  input  cpuOpT cpuOp,
  input  addrT  cpuAddr,
  input  wordT  cpuWdata,
  output wordT  cpuRdata,
  output logic  cpuReady
);

  // block bus between cache and memory
  memBusIf memBus ();

  // processor side, answers hits and runs misses
  cacheController cacheCtrl (
    .clk      (clk),
    .rstN     (rstN),
    .cpuReq   (cpuReq),
    .cpuOp    (cpuOp),
    .cpuAddr  (cpuAddr),
    .cpuWdata (cpuWdata),
    .cpuRdata (cpuRdata),
    .cpuReady (cpuReady),
    .bus      (memBus.master)
  );

  // slow main memory model
  blockMemory blockMem (
    .clk  (clk),
    .rstN (rstN),
    .bus  (memBus.slave)
  );

endmodule

`default_nettype wire

/* verif/memSubsystemTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_consts.svh"

module memSubsystemTb import memTypesPkg::*, cacheTypesPkg::*; ();

  // about 120 requests at 20 cycles each, plus reset and margin
  localparam int NumRequests   = 120;
  localparam int TimeoutCycles = NumRequests * 20 + 1600;
  localparam int ReadyLimit    = 20;

  logic  clk;
  logic  rstN;
  logic  cpuReq;
  cpuOpT cpuOp;
  addrT  cpuAddr;
  wordT  cpuWdata;
  wordT  cpuRdata;
  logic  cpuReady;

  int valueErrors;
  int otherErrors;
  int cycleCount;
  int lastLatency;

  // expected memory contents as words inside the window
  wordT refMem [`MEM_WORDS];

  memSubsystem memSubsystem_inst (
    .clk      (clk),
    .rstN     (rstN),
    .cpuReq   (cpuReq),
    .cpuOp    (cpuOp),
    .cpuAddr  (cpuAddr),
    .cpuWdata (cpuWdata),
    .cpuRdata (cpuRdata),
    .cpuReady (cpuReady)
  );

  // 8 ns clock
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // hard stop on a stuck run
  initial
  begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Testbench failed");
    $finish;
  end

  // preload rule of main memory
  function automatic wordT preloadValue(input int wordAddr);
    return (wordT'(wordAddr) * 32'h01010101) ^ 32'hA5A50000;
  endfunction

  // word address from bits 13..2 so higher bits alias into the 16 KB window
  function automatic int wordIndex(input addrT addr);
    return int'(addr[13:2]);
  endfunction

  task automatic compareWord(input string name, input wordT got, input wordT exp);
    if (got !== exp)
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      valueErrors++;
    end
  endtask

  task automatic compareState(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      valueErrors++;
    end
  endtask

  // strobe one request, wait for ready, sample at the falling edge
  task automatic request(input cpuOpT op, input addrT addr, input wordT wdata,
                         output wordT rdata);
    int waited;
    cpuReq   = 1'b1;
    cpuOp    = op;
    cpuAddr  = addr;
    cpuWdata = wdata;
    @(posedge clk);
    #1;
    cpuReq = 1'b0;
    waited = 0;
    rdata  = '0;
    do
    begin
      @(negedge clk);
      waited++;
    end while (!cpuReady && waited < ReadyLimit);
    if (!cpuReady)
    begin
      $display("No ready within %0d cycles for request to address %h", ReadyLimit, addr);
      otherErrors++;
    end
    else
      rdata = cpuRdata;
    lastLatency = waited;
    // back to the drive point
    @(posedge clk);
    #1;
  endtask

  task automatic checkHitLatency(input addrT addr);
    if (lastLatency != 1)
    begin
      $display("Hit at address %h answered after %0d cycles instead of 1", addr, lastLatency);
      otherErrors++;
    end
  endtask

  task automatic loadCheck(input addrT addr, input logic expectHit);
    wordT got;
    request(opLoad, addr, '0, got);
    compareWord($sformatf("cpuRdata @%h", addr), got, refMem[wordIndex(addr)]);
    if (expectHit)
      checkHitLatency(addr);
  endtask

  task automatic storeWord(input addrT addr, input wordT data, input logic expectHit);
    wordT ignored;
    request(opStore, addr, data, ignored);
    refMem[wordIndex(addr)] = data;
    if (expectHit)
      checkHitLatency(addr);
  endtask

  task automatic readyLowAfterReset();
    repeat (3)
    begin
      @(negedge clk);
      compareState("cpuReady", cpuReady, 1'b0);
    end
    @(posedge clk);
    #1;
  endtask

  // cold miss, then the same word as a hit
  task automatic coldLoad();
    loadCheck(32'h0000_0040, 1'b0);
    loadCheck(32'h0000_0040, 1'b1);
  endtask

  // one refill serves all four words
  task automatic blockRefill();
    loadCheck(32'h0000_0120, 1'b0);
    for (int w = 0; w < `BLOCK_WORDS; w++)
      loadCheck(32'h0000_0120 + addrT'(w * 4), 1'b1);
  endtask

  task automatic storeThenLoad();
    storeWord(32'h0000_0124, 32'hDEAD_BEEF, 1'b1);
    loadCheck(32'h0000_0124, 1'b1);
  endtask

  // index 5 with tag 3 against tag 7
  task automatic dirtyEviction();
    storeWord(32'h0000_0350, 32'h0BAD_F00D, 1'b0);
    loadCheck(32'h0000_0750, 1'b0);
    loadCheck(32'h0000_0350, 1'b0);
  endtask

  task automatic randomMix();
    addrT       addr;
    logic [5:0] tag;
    for (int n = 0; n < 100; n++)
    begin
      // 4 tags x 4 lines x 4 words
      tag  = 6'((($urandom % 4) * 13) + 2);
      addr = {18'h0, tag, 4'($urandom % 4), 2'($urandom % 4), 2'b00};
      // some requests carry bits above the window
      if ($urandom % 4 == 0)
        addr[31:14] = 18'($urandom);
      if ($urandom % 2 == 0)
        loadCheck(addr, 1'b0);
      else
        storeWord(addr, wordT'($urandom), 1'b0);
    end
  endtask

  initial
  begin
    void'($urandom(32'h6e5));
    valueErrors = 0;
    otherErrors = 0;
    lastLatency = 0;
    rstN        = 1'b0;
    cpuReq      = 1'b0;
    cpuOp       = opLoad;
    cpuAddr     = '0;
    cpuWdata    = '0;
    for (int i = 0; i < `MEM_WORDS; i++)
      refMem[i] = preloadValue(i);
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;
    readyLowAfterReset();
    coldLoad();
    blockRefill();
    storeThenLoad();
    dirtyEviction();
    randomMix();
    $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
hw/memTypesPkg.sv
hw/cacheTypesPkg.sv
hw/memBusIf.sv
hw/blockMemory.sv
hw/cacheController.sv
hw/memSubsystem.sv
verif/memSubsystemTb.sv

/* run.sh */
#!/bin/sh
# compile and run the cache subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f \
  --top-module memSubsystemTb \
  -Mdir obj_dir

# keep the log even when the simulation exits with an error
status=0
./obj_dir/VmemSubsystemTb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "Testbench passed" sim.log; then
  exit 0
fi
exit 1
